//--- Bender.yml
package:
  name: core

sources:
  - common/core_pkg.sv
  - hw/stage_reg.sv
  - hw/decode/reg_file.sv
  - hw/decode/decode_stage.sv
  - hw/execute/execute_stage.sv
  - hw/result_stage.sv
  - hw/host_port.sv
  - hw/core.sv
  - target: test
    files:
      - bench/core_assert.sv
      - bench/core_tb.sv

//--- bench/core_assert.sv
`timescale 1ns/100ps

module core_assert (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input core_pkg::word_t prdata,
	input logic dec_valid,
	input logic res_valid
);

	int fails = 0;      // Failure count, read at end of run
	logic access;

	assign access = psel && penable;

	// Slave answers only in the access phase
	resp_in_access: assert property (@(posedge clk) disable iff (!arst_n)
		!access |-> !pready && !pslverr)
	else begin
		$error("pready or pslverr high outside an APB access phase");
		fails++;
	end

	// Read data holds across wait states
	data_held: assert property (@(posedge clk) disable iff (!arst_n)
		(access && !pready) ##1 (access && !pready) |-> $stable(prdata))
	else begin
		$error("prdata changed while pready was low");
		fails++;
	end

	valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({dec_valid, res_valid}))
	else begin
		$error("pipeline valid bit is unknown");
		fails++;
	end

endmodule

bind core core_assert i_assert (
	.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pready(pready),
	.pslverr(pslverr), .prdata(prdata), .dec_valid(dec_q_valid), .res_valid(res_q_valid)
);

//--- bench/core_tb.sv
`timescale 1ns/100ps

module core_tb;

	localparam int n_tests = 6;
	localparam int prog_max = 64;       // Longest program, in words
	localparam int margin = 2000;       // APB load, polls and dumps per test
	localparam int idle_polls = 400;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [core_pkg::addr_w-1:0] paddr;
	core_pkg::word_t pwdata;
	core_pkg::word_t prdata;
	logic pready;
	logic pslverr;

	logic [31:0] lfsr_q = 32'd95954;
	core_pkg::word_t m_reg [32];                    // Reference register file
	core_pkg::word_t m_mem [core_pkg::dmem_words];  // Reference data memory
	core_pkg::word_t prog [$];
	string test_name;
	int errors = 0;
	int test_errors;
	int tests_done = 0;
	int last_waits;                                 // Access cycles with pready low
	logic last_err;

	core i_dut (
		.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #10 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic core_pkg::word_t lfsr_bits(input int n);
		core_pkg::word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// RV32I integer ops by funct3
	function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input core_pkg::word_t a, input core_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [core_pkg::addr_w-1:0] dmem_addr(input logic [7:0] idx);
		return core_pkg::dmem_base + {2'b00, idx, 2'b00};
	endfunction

	// Program builders, each also steps the model
	task automatic rtype_op(input logic [2:0] f3, input logic alt, input core_pkg::reg_idx_t rd,
		input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2);
		prog.push_back({1'b0, alt, 5'b0, rs2, rs1, f3, rd, core_pkg::op_reg});
		if (rd != '0)
			m_reg[rd] = alu_ref(f3, alt, m_reg[rs1], m_reg[rs2]);
	endtask

	task automatic itype_op(input logic [2:0] f3, input core_pkg::reg_idx_t rd,
		input core_pkg::reg_idx_t rs1, input logic [11:0] imm);
		prog.push_back({imm, rs1, f3, rd, core_pkg::op_imm});
		if (rd != '0)     // imm[10] marks SRAI
			m_reg[rd] = alu_ref(f3, f3 == 3'd5 && imm[10], m_reg[rs1], {{20{imm[11]}}, imm});
	endtask

	task automatic lui_op(input core_pkg::reg_idx_t rd, input logic [19:0] imm);
		prog.push_back({imm, rd, core_pkg::op_lui});
		if (rd != '0)
			m_reg[rd] = {imm, 12'b0};
	endtask

	task automatic store_word(input core_pkg::reg_idx_t rs2, input logic [7:0] idx);
		logic [11:0] off;
		off = {2'b00, idx, 2'b00};      // Base is x0
		prog.push_back({off[11:5], rs2, 5'd0, 3'b010, off[4:0], core_pkg::op_store});
		m_mem[idx] = m_reg[rs2];
	endtask

	task automatic load_word(input core_pkg::reg_idx_t rd, input logic [7:0] idx);
		prog.push_back({2'b00, idx, 2'b00, 5'd0, 3'b010, rd, core_pkg::op_load});
		if (rd != '0)
			m_reg[rd] = m_mem[idx];
	endtask

	// SW x1..x31 to base+1..base+31, then ECALL
	task automatic store_all(input int base);
		for (int i = 1; i < 32; i++)
			store_word(core_pkg::reg_idx_t'(i), 8'(base + i));
		prog.push_back(32'h0000_0073);
	endtask

	task automatic random_program(input int n_ops, input int base);
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs1;
		core_pkg::reg_idx_t rs2;
		core_pkg::reg_idx_t prev;
		logic [2:0] f3;
		logic [1:0] kind;
		logic [11:0] imm;
		prog.delete();
		prev = 5'd1;
		for (int k = 0; k < n_ops; k++) begin
			kind = 2'(lfsr_bits(2));
			f3 = 3'(lfsr_bits(3));
			rd = core_pkg::reg_idx_t'(lfsr_bits(5));
			// Lean on the previous rd for back-to-back dependencies
			rs1 = (lfsr_bits(1) != 0) ? prev : core_pkg::reg_idx_t'(lfsr_bits(5));
			rs2 = (lfsr_bits(1) != 0) ? prev : core_pkg::reg_idx_t'(lfsr_bits(5));
			if (kind == 2'd3) begin
				lui_op(rd, 20'(lfsr_bits(20)));
			end else if (kind == 2'd2) begin
				if (f3 == 3'd1)
					imm = {7'h00, 5'(lfsr_bits(5))};
				else if (f3 == 3'd5)
					imm = {(lfsr_bits(1) != 0) ? 7'h20 : 7'h00, 5'(lfsr_bits(5))};
				else
					imm = 12'(lfsr_bits(12));
				itype_op(f3, rd, rs1, imm);
			end else begin
				rtype_op(f3, (f3 == 3'd0 || f3 == 3'd5) && lfsr_bits(1) != 0, rd, rs1, rs2);
			end
			if (rd != '0)
				prev = rd;
		end
		store_all(base);
	endtask

	task automatic load_use_program(input int base);
		core_pkg::reg_idx_t other;
		prog.delete();
		for (int j = 0; j < 4; j++) begin
			other = core_pkg::reg_idx_t'(lfsr_bits(5));
			load_word(core_pkg::reg_idx_t'(8 + j), 8'(lfsr_bits(8)));
			rtype_op(3'(lfsr_bits(3)), 1'b0, core_pkg::reg_idx_t'(12 + j),
				core_pkg::reg_idx_t'(8 + j), other);                 // Loaded reg as rs1
			load_word(core_pkg::reg_idx_t'(24 + j), 8'(lfsr_bits(8)));
			rtype_op(3'd0, j[0], core_pkg::reg_idx_t'(16 + j), other,
				core_pkg::reg_idx_t'(24 + j));                       // ... and as rs2
		end
		load_word(5'd28, 8'(lfsr_bits(8)));
		store_word(5'd28, 8'(base + 32));       // Store data straight from a load
		store_all(base);
	endtask

	// One APB transfer, setup then access until pready
	task automatic bus_cycle(input logic wr, input logic [core_pkg::addr_w-1:0] addr,
		input core_pkg::word_t wdata, output core_pkg::word_t rdata);
		int waits;
		waits = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			waits++;
			@(negedge clk);
			#1;
		end
		rdata = prdata;     // Held until the completing edge
		last_err = pslverr;
		last_waits = waits;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [core_pkg::addr_w-1:0] addr, input core_pkg::word_t data);
		core_pkg::word_t unused;
		bus_cycle(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [core_pkg::addr_w-1:0] addr, output core_pkg::word_t data);
		bus_cycle(1'b0, addr, '0, data);
	endtask

	task automatic check_word(input string what, input core_pkg::word_t exp,
		input core_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: %s expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_err(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: %s expected pslverr %b, actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic wait_idle();
		core_pkg::word_t ctrl;
		int polls;
		polls = 0;
		ctrl = 32'd1;
		while (ctrl[0] && polls < idle_polls) begin
			apb_read(core_pkg::ctrl_addr, ctrl);
			polls++;
		end
		if (ctrl[0] !== 1'b0) begin
			$display("%s: core still busy after %0d status polls", test_name, polls);
			errors++;
		end
	endtask

	task automatic load_program();
		foreach (prog[i])
			apb_write(core_pkg::imem_base + 12'(4 * i), prog[i]);
	endtask

	task automatic run_program();
		load_program();
		apb_write(core_pkg::ctrl_addr, 32'd1);
		wait_idle();
	endtask

	task automatic compare_dmem(input int lo, input int n);
		core_pkg::word_t v;
		logic [7:0] idx;
		for (int i = 0; i < n; i++) begin
			idx = 8'(lo + i);
			apb_read(dmem_addr(idx), v);
			check_word($sformatf("dmem[%0d]", idx), m_mem[idx], v);
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic close_test();
		tests_done++;
		if (errors == test_errors)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - test_errors);
	endtask

	initial begin
		core_pkg::word_t v;
		int total;
		clk = 1'b0;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 32; i++)
			m_reg[i] = '0;      // Register file resets to zero
		repeat (3) @(negedge clk);
		arst_n = 1'b1;

		open_test("reset_status");
		apb_read(core_pkg::ctrl_addr, v);
		check_word("control word", 32'd0, v);
		check_err("control read", 1'b0, last_err);
		close_test();

		open_test("dmem_rw");   // Also fills the whole model memory
		for (int i = 0; i < core_pkg::dmem_words; i++) begin
			m_mem[i] = lfsr_bits(32);
			apb_write(dmem_addr(8'(i)), m_mem[i]);
		end
		compare_dmem(0, core_pkg::dmem_words);
		close_test();

		open_test("random_programs");
		for (int p = 0; p < 3; p++) begin
			random_program(30, p * 64);
			run_program();
		end
		compare_dmem(0, core_pkg::dmem_words);
		close_test();

		open_test("load_use");
		load_use_program(200);
		run_program();
		compare_dmem(200, 33);
		close_test();

		open_test("read_while_busy");
		random_program(30, 96);
		load_program();
		apb_write(core_pkg::ctrl_addr, 32'd1);
		apb_read(dmem_addr(8'd103), v);     // Held off until the halt
		if (last_waits == 0) begin
			$display("%s: dmem read completed without waiting for the program", test_name);
			errors++;
		end
		check_word("dmem[103]", m_mem[103], v);
		apb_read(core_pkg::ctrl_addr, v);
		check_word("control word", 32'd0, v);
		close_test();

		open_test("bad_address");
		apb_write(12'h802, lfsr_bits(32));
		check_err("misaligned dmem write", 1'b1, last_err);
		apb_write(12'hC00, lfsr_bits(32));
		check_err("unmapped write", 1'b1, last_err);
		apb_read(12'hC04, v);
		check_err("unmapped read", 1'b1, last_err);
		apb_write(12'h001, 32'd1);          // Must not start the core
		check_err("misaligned control write", 1'b1, last_err);
		apb_read(core_pkg::ctrl_addr, v);
		check_word("control word", 32'd0, v);
		compare_dmem(0, 2);
		close_test();

		total = errors + i_dut.i_assert.fails;
		$display("%0d tests, %0d errors, %0d assertion failures", tests_done, errors,
			i_dut.i_assert.fails);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (n_tests * (prog_max + margin)) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", n_tests * (prog_max + margin));
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- common/core_pkg.sv
package core_pkg;

	// Datapath and memory sizes
	localparam int xlen = 32;
	localparam int imem_words = 256;
	localparam int dmem_words = 256;

	// Host address map, byte addresses on paddr
	localparam int addr_w = 12;
	localparam int region_lsb = 10;                 // Each window spans 1 KiB
	localparam logic [addr_w-1:0] ctrl_addr = 12'h000;
	localparam logic [addr_w-1:0] imem_base = 12'h400;
	localparam logic [addr_w-1:0] dmem_base = 12'h800;

	typedef logic [4:0] reg_idx_t;
	typedef logic [xlen-1:0] word_t;
	typedef logic [$clog2(imem_words)-1:0] pc_t;    // Word address into imem

	// RV32I major opcodes kept by this core
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_system = 7'b1110011;  // ECALL halts the core

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b                                  // LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_none,
		wb_alu,
		wb_load
	} wb_sel_t;

	// Decode to execute
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t op_a;        // Register file values at decode time
		word_t op_b;
		word_t imm;
		logic use_imm;
		alu_op_t alu_op;
		wb_sel_t wb_sel;
		logic is_store;
		logic is_halt;
	} dec_exe_t;

	// Execute to result
	typedef struct packed {
		reg_idx_t rd;
		word_t alu_res;     // Also the load/store byte address
		word_t store_data;
		wb_sel_t wb_sel;
		logic is_store;
		logic is_halt;
	} exe_res_t;

	typedef struct packed {
		logic we;
		reg_idx_t rd;
		word_t value;
	} wb_t;

	// Host side memory request
	typedef struct packed {
		logic we;
		logic [$clog2(dmem_words)-1:0] idx;
		word_t wdata;
	} host_mem_t;

endpackage

//--- core.f
common/core_pkg.sv
hw/stage_reg.sv
hw/decode/reg_file.sv
hw/decode/decode_stage.sv
hw/execute/execute_stage.sv
hw/result_stage.sv
hw/host_port.sv
hw/core.sv
bench/core_assert.sv
bench/core_tb.sv

//--- hw/core.sv
`timescale 1ns/100ps

module core (
	input  logic clk,
	input  logic arst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [core_pkg::addr_w-1:0] paddr,
	input  core_pkg::word_t pwdata,
	output core_pkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	// Host side
	logic start;
	logic halted;
	core_pkg::host_mem_t host_imem;
	core_pkg::host_mem_t host_dmem;
	core_pkg::word_t dmem_rdata;

	// Decode and register file
	logic stall;
	core_pkg::reg_idx_t rs1, rs2;
	core_pkg::word_t rdata1, rdata2;
	core_pkg::reg_idx_t exe_rd;
	logic exe_is_load;

	// Stage payloads, d side into a stage_reg and q side out of it
	core_pkg::dec_exe_t dec_d, dec_q;
	logic dec_d_valid, dec_q_valid;
	core_pkg::exe_res_t exe_d, res_q;
	logic exe_d_valid, res_q_valid;
	core_pkg::wb_t wb;

	host_port i_host (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .halted(halted),
		.host_imem(host_imem), .host_dmem(host_dmem), .dmem_rdata(dmem_rdata)
	);

	decode_stage i_decode (
		.clk(clk), .arst_n(arst_n), .start(start), .host_imem(host_imem),
		.stall(stall), .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.exe_rd(exe_rd), .exe_is_load(exe_is_load),
		.dec(dec_d), .dec_valid(dec_d_valid)
	);

	reg_file i_rf (
		.clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2),
		.rdata1(rdata1), .rdata2(rdata2), .wb(wb)
	);

	// Load-use stall turns this slot into a bubble
	stage_reg #(.payload_t(core_pkg::dec_exe_t)) i_dec_exe (
		.clk(clk), .arst_n(arst_n), .in_data(dec_d), .in_valid(dec_d_valid),
		.bubble(stall), .out_data(dec_q), .out_valid(dec_q_valid)
	);

	execute_stage i_execute (
		.dec(dec_q), .dec_valid(dec_q_valid), .res_fwd(res_q), .res_valid(res_q_valid),
		.wb(wb), .exe(exe_d), .exe_valid(exe_d_valid),
		.exe_rd(exe_rd), .exe_is_load(exe_is_load)
	);

	stage_reg #(.payload_t(core_pkg::exe_res_t)) i_exe_res (
		.clk(clk), .arst_n(arst_n), .in_data(exe_d), .in_valid(exe_d_valid),
		.bubble(1'b0), .out_data(res_q), .out_valid(res_q_valid)     // Never stalls
	);

	result_stage i_result (
		.clk(clk), .arst_n(arst_n), .res(res_q), .res_valid(res_q_valid),
		.host_dmem(host_dmem), .dmem_rdata(dmem_rdata), .wb(wb), .halted(halted)
	);

endmodule

//--- hw/decode/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  core_pkg::host_mem_t host_imem,
	output logic stall,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	input  core_pkg::word_t rdata1,
	input  core_pkg::word_t rdata2,
	input  core_pkg::reg_idx_t exe_rd,
	input  logic exe_is_load,
	output core_pkg::dec_exe_t dec,
	output logic dec_valid
);

	core_pkg::word_t imem [core_pkg::imem_words];
	core_pkg::pc_t pc_q;
	core_pkg::word_t instr_q;   // Synchronous imem output
	logic fetch_q;              // instr_q holds a live instruction
	logic run_q;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic use_rs1, use_rs2;
	logic halt_dec;
	core_pkg::word_t imm_i, imm_s, imm_u;

	// funct3 to ALU op, alt picks sub or sra
	function automatic core_pkg::alu_op_t alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? core_pkg::alu_sub : core_pkg::alu_add;
			3'd1: return core_pkg::alu_sll;
			3'd2: return core_pkg::alu_slt;
			3'd3: return core_pkg::alu_sltu;
			3'd4: return core_pkg::alu_xor;
			3'd5: return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'd6: return core_pkg::alu_or;
			default: return core_pkg::alu_and;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (host_imem.we)
			imem[host_imem.idx] <= host_imem.wdata;     // Host program load
		if (!stall)
			instr_q <= imem[pc_q];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
			run_q <= 1'b0;
			fetch_q <= 1'b0;
		end else if (start) begin
			pc_q <= '0;
			run_q <= 1'b1;
			fetch_q <= 1'b0;
		end else if (!stall) begin
			fetch_q <= run_q && !halt_dec;  // Drop whatever follows the halt
			if (run_q && !halt_dec)
				pc_q <= pc_q + core_pkg::pc_t'(1);
			if (halt_dec)
				run_q <= 1'b0;
		end
	end

	// Fields
	assign opcode = instr_q[6:0];
	assign funct3 = instr_q[14:12];
	assign funct7 = instr_q[31:25];
	assign rs1 = instr_q[19:15];
	assign rs2 = instr_q[24:20];

	assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
	assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
	assign imm_u = {instr_q[31:12], 12'b0};

	// Which source fields are real registers
	assign use_rs1 = opcode inside {core_pkg::op_reg, core_pkg::op_imm,
		core_pkg::op_load, core_pkg::op_store};
	assign use_rs2 = opcode inside {core_pkg::op_reg, core_pkg::op_store};
	assign halt_dec = fetch_q && opcode == core_pkg::op_system;

	// Load in execute feeding this instruction
	assign stall = fetch_q && exe_is_load && exe_rd != '0 &&
		((use_rs1 && rs1 == exe_rd) || (use_rs2 && rs2 == exe_rd));

	always_comb begin
		dec = '0;
		dec.rs1 = rs1;
		dec.rs2 = rs2;
		dec.rd = instr_q[11:7];
		dec.op_a = rdata1;
		dec.op_b = rdata2;
		dec.imm = imm_i;
		dec.alu_op = core_pkg::alu_add;
		dec.wb_sel = core_pkg::wb_none;     // Unknown opcodes retire as no-ops
		case (opcode)
			core_pkg::op_reg: begin
				dec.alu_op = alu_of(funct3, funct7[5]);
				dec.wb_sel = core_pkg::wb_alu;
			end
			core_pkg::op_imm: begin
				dec.use_imm = 1'b1;
				dec.alu_op = alu_of(funct3, funct3 == 3'd5 && funct7[5]);   // SRAI only
				dec.wb_sel = core_pkg::wb_alu;
			end
			core_pkg::op_lui: begin
				dec.imm = imm_u;
				dec.use_imm = 1'b1;
				dec.alu_op = core_pkg::alu_pass_b;
				dec.wb_sel = core_pkg::wb_alu;
			end
			core_pkg::op_load: begin
				dec.use_imm = 1'b1;             // Address rs1 + imm
				dec.wb_sel = core_pkg::wb_load;
			end
			core_pkg::op_store: begin
				dec.imm = imm_s;
				dec.use_imm = 1'b1;
				dec.is_store = 1'b1;
			end
			core_pkg::op_system: dec.is_halt = 1'b1;
			default: ;
		endcase
	end

	assign dec_valid = fetch_q;

endmodule

//--- hw/decode/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic clk,
	input  logic arst_n,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	output core_pkg::word_t rdata1,
	output core_pkg::word_t rdata2,
	input  core_pkg::wb_t wb
);

	core_pkg::word_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.we && wb.rd != '0) begin
			regs[wb.rd] <= wb.value;    // x0 never written
		end
	end

	// Same-cycle write shows through to decode
	assign rdata1 = (wb.we && wb.rd != '0 && wb.rd == rs1) ? wb.value : regs[rs1];
	assign rdata2 = (wb.we && wb.rd != '0 && wb.rd == rs2) ? wb.value : regs[rs2];

endmodule

//--- hw/execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  core_pkg::dec_exe_t dec,
	input  logic dec_valid,
	input  core_pkg::exe_res_t res_fwd,
	input  logic res_valid,
	input  core_pkg::wb_t wb,
	output core_pkg::exe_res_t exe,
	output logic exe_valid,
	output core_pkg::reg_idx_t exe_rd,
	output logic exe_is_load
);

	core_pkg::word_t src_a;     // Forwarded rs1
	core_pkg::word_t src_b;     // Forwarded rs2, also the store data
	core_pkg::word_t opb;
	core_pkg::word_t alu_res;

	// Youngest producer wins, the result stage ahead of write-back
	function automatic core_pkg::word_t pick(
		input core_pkg::reg_idx_t src,
		input core_pkg::word_t read_val,
		input core_pkg::exe_res_t res_in,
		input logic res_ok,
		input core_pkg::wb_t wb_in
	);
		if (src == '0)
			return read_val;        // x0 reads zero already
		if (res_ok && res_in.wb_sel == core_pkg::wb_alu && res_in.rd == src)
			return res_in.alu_res;  // Loads excluded here
		if (wb_in.we && wb_in.rd == src)
			return wb_in.value;
		return read_val;
	endfunction

	assign src_a = pick(dec.rs1, dec.op_a, res_fwd, res_valid, wb);
	assign src_b = pick(dec.rs2, dec.op_b, res_fwd, res_valid, wb);
	assign opb = dec.use_imm ? dec.imm : src_b;

	always_comb begin
		case (dec.alu_op)
			core_pkg::alu_add: alu_res = src_a + opb;
			core_pkg::alu_sub: alu_res = src_a - opb;
			core_pkg::alu_sll: alu_res = src_a << opb[4:0];
			core_pkg::alu_slt: alu_res = core_pkg::word_t'($signed(src_a) < $signed(opb));
			core_pkg::alu_sltu: alu_res = core_pkg::word_t'(src_a < opb);
			core_pkg::alu_xor: alu_res = src_a ^ opb;
			core_pkg::alu_srl: alu_res = src_a >> opb[4:0];
			core_pkg::alu_sra: alu_res = core_pkg::word_t'($signed(src_a) >>> opb[4:0]);
			core_pkg::alu_or: alu_res = src_a | opb;
			core_pkg::alu_and: alu_res = src_a & opb;
			core_pkg::alu_pass_b: alu_res = opb;   // LUI immediate
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		exe.rd = dec.rd;
		exe.alu_res = alu_res;
		exe.store_data = src_b;
		exe.wb_sel = dec.wb_sel;
		exe.is_store = dec.is_store;
		exe.is_halt = dec.is_halt;
	end

	assign exe_valid = dec_valid;

	// For the load-use check in decode
	assign exe_rd = dec.rd;
	assign exe_is_load = dec_valid && dec.wb_sel == core_pkg::wb_load;

endmodule

//--- hw/host_port.sv
`timescale 1ns/100ps

module host_port (
	input  logic clk,
	input  logic arst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [core_pkg::addr_w-1:0] paddr,
	input  core_pkg::word_t pwdata,
	output core_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	input  logic halted,
	output core_pkg::host_mem_t host_imem,
	output core_pkg::host_mem_t host_dmem,
	input  core_pkg::word_t dmem_rdata
);

	localparam int aw = core_pkg::addr_w;
	localparam int rl = core_pkg::region_lsb;

	logic access;               // APB access phase
	logic aligned;
	logic ctrl_hit, imem_hit, dmem_hit;
	logic err;
	logic wr;                   // Completing, error-free write
	logic busy_q;

	assign access = psel && penable;
	assign aligned = paddr[1:0] == 2'b00;

	// Region decode
	assign ctrl_hit = paddr == core_pkg::ctrl_addr;
	assign imem_hit = aligned && paddr[aw-1:rl] == core_pkg::imem_base[aw-1:rl];
	assign dmem_hit = aligned && paddr[aw-1:rl] == core_pkg::dmem_base[aw-1:rl];
	assign err = !(ctrl_hit || imem_hit || dmem_hit);

	// Memories wait out a running program, control and errors never wait
	assign pready = access && (err || ctrl_hit || !busy_q);
	assign pslverr = access && err;
	assign wr = pready && pwrite && !err;

	// Restart ignored while a program runs
	assign start = wr && ctrl_hit && pwdata[0] && !busy_q;

	assign host_imem = '{we: wr && imem_hit, idx: paddr[rl-1:2], wdata: pwdata};
	assign host_dmem = '{we: wr && dmem_hit, idx: paddr[rl-1:2], wdata: pwdata};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy_q <= 1'b0;
		else if (start)
			busy_q <= 1'b1;
		else if (halted)
			busy_q <= 1'b0;    // Halt left the result stage
	end

	// Read data only in the completing cycle, imem reads back as zero
	always_comb begin
		prdata = '0;
		if (pready && !pwrite && !err) begin
			if (ctrl_hit)
				prdata = core_pkg::word_t'(busy_q);
			else if (dmem_hit)
				prdata = dmem_rdata;
		end
	end

endmodule

//--- hw/result_stage.sv
`timescale 1ns/100ps

module result_stage (
	input  logic clk,
	input  logic arst_n,
	input  core_pkg::exe_res_t res,
	input  logic res_valid,
	input  core_pkg::host_mem_t host_dmem,
	output core_pkg::word_t dmem_rdata,
	output core_pkg::wb_t wb,
	output logic halted
);

	localparam int idx_w = $clog2(core_pkg::dmem_words);

	core_pkg::word_t dmem [core_pkg::dmem_words];
	logic [idx_w-1:0] res_idx;
	logic store_we;
	core_pkg::word_t load_data;

	assign res_idx = res.alu_res[2 +: idx_w];   // Word index, low bits ignored
	assign store_we = arst_n && res_valid && res.is_store;    // No writes while in reset

	// Core store first, host only writes while idle
	always_ff @(posedge clk) begin
		if (store_we)
			dmem[res_idx] <= res.store_data;
		else if (host_dmem.we)
			dmem[host_dmem.idx] <= host_dmem.wdata;
	end

	assign load_data = dmem[res_idx];
	assign dmem_rdata = dmem[host_dmem.idx];    // Host read port

	always_comb begin
		wb.we = res_valid && res.wb_sel != core_pkg::wb_none;
		wb.rd = res.rd;
		wb.value = (res.wb_sel == core_pkg::wb_load) ? load_data : res.alu_res;
	end

	assign halted = res_valid && res.is_halt;     // One cycle per halt

endmodule

//--- hw/stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic arst_n,
	input  payload_t in_data,
	input  logic in_valid,
	input  logic bubble,
	output payload_t out_data,
	output logic out_valid
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid && !bubble;   // Bubble kills the slot
	end

	// Payload held through a bubble
	always_ff @(posedge clk) begin
		if (!bubble)
			out_data <= in_data;
	end

endmodule
